// ==== verilog/cdc_fifo_defs.svh ====
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// fifo geometry
////////////////////////////////////////////////////////////////////////////

// width of one stored word
`define CDC_FIFO_DATA_W 8

// array index width
// pointers carry one extra wrap bit above this
`define CDC_FIFO_ADDR_W 3

// number of entries, must stay 2**CDC_FIFO_ADDR_W
// the gray full/empty compare relies on a power of two depth
`define CDC_FIFO_DEPTH 8

`endif

// ==== verilog/cdc_fifo_pkg.sv ====
`include "cdc_fifo_defs.svh"

package cdc_fifo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// basic types
	////////////////////////////////////////////////////////////////////////////

	// one stored word
	typedef logic [`CDC_FIFO_DATA_W-1:0] data_t;

	// array index
	typedef logic [`CDC_FIFO_ADDR_W-1:0] addr_t;

	// pointer with wrap bit on top
	// same type for binary and gray form
	typedef logic [`CDC_FIFO_ADDR_W:0] ptr_t;

	////////////////////////////////////////////////////////////////////////////
	// array request structs
	////////////////////////////////////////////////////////////////////////////

	// write request, write clock domain
	typedef struct packed {
		logic  enable;
		addr_t addr;
		data_t data;
	} array_wr_t;

	// read request, read clock domain
	typedef struct packed {
		logic  enable;
		addr_t addr;
	} array_rd_t;

endpackage

// ==== verilog/cdc_fifo_reg_array.sv ====
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_fifo_reg_array
	import cdc_fifo_pkg::*;
(
	input  logic      clk_write,
	input  logic      rst_n_write,
	input  array_wr_t wr,
	input  logic      clk_read,
	input  logic      rst_n_read,
	input  array_rd_t rd,
	output data_t     read_data
);

	// storage owned by the write domain
	data_t mem [`CDC_FIFO_DEPTH];

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	// entries cleared on write reset
	// one entry written per accepted write
	always_ff @(posedge clk_write or negedge rst_n_write) begin
		if (!rst_n_write) begin
			for (int i = 0; i < `CDC_FIFO_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wr.enable) begin
			mem[wr.addr] <= wr.data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////////////////////

	// registered read
	// holds last word when no read is accepted
	// entry read here is stable
	// gray sync means its write finished earlier
	always_ff @(posedge clk_read or negedge rst_n_read) begin
		if (!rst_n_read) begin
			read_data <= '0;
		end else if (rd.enable) begin
			read_data <= mem[rd.addr];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// write address must be known whenever a write lands
	a_wr_addr_known: assert property (
		@(posedge clk_write) disable iff (!rst_n_write)
		wr.enable |-> !$isunknown(wr.addr)
	) else $error("write address unknown while write enable is high");

endmodule

// ==== verilog/gray_ptr_sync.sv ====
`timescale 1ns/1ps

module gray_ptr_sync
	import cdc_fifo_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  ptr_t async_ptr,
	output ptr_t sync_ptr
);

	////////////////////////////////////////////////////////////////////////////
	// two flop synchronizer
	////////////////////////////////////////////////////////////////////////////

	// first stage may go metastable
	ptr_t meta_ptr;

	// input is gray coded
	// at most one bit flips per source edge
	// so a late sample lands on the old or the new value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			meta_ptr <= '0;
			sync_ptr <= '0;
		end else begin
			// stage 1 samples the other domain
			meta_ptr <= async_ptr;
			// stage 2 gives time to settle
			sync_ptr <= meta_ptr;
		end
	end

endmodule

// ==== verilog/cdc_fifo_write_ctrl.sv ====
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_fifo_write_ctrl
	import cdc_fifo_pkg::*;
(
	input  logic      clk_write,
	input  logic      rst_n_write,
	input  data_t     write_data,
	input  logic      write_en,
	input  ptr_t      rd_gray_sync,
	output logic      full,
	output array_wr_t wr,
	output ptr_t      wr_gray
);

	// binary write pointer, wrap bit on top
	ptr_t wr_bin;

	// next state
	ptr_t wr_bin_next;
	ptr_t wr_gray_next;
	ptr_t rd_gray_wrapped;
	logic full_next;
	logic write_accept;

	////////////////////////////////////////////////////////////////////////////
	// next pointer and full flag
	////////////////////////////////////////////////////////////////////////////

	// writes while full are dropped
	assign write_accept = write_en && !full;

	always_comb begin
		// advance by one on an accepted write
		wr_bin_next  = wr_bin + ptr_t'(write_accept);
		// binary to gray
		wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

		// read pointer one lap behind
		// in gray form that is the top two bits inverted
		rd_gray_wrapped = {~rd_gray_sync[`CDC_FIFO_ADDR_W:`CDC_FIFO_ADDR_W-1],
			rd_gray_sync[`CDC_FIFO_ADDR_W-2:0]};
		full_next = (wr_gray_next == rd_gray_wrapped);
	end

	// array write request
	always_comb begin
		wr.enable = write_accept;
		wr.addr   = wr_bin[`CDC_FIFO_ADDR_W-1:0];
		wr.data   = write_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// full updates every edge
	// rises with the filling write, falls once the read pointer catches up
	always_ff @(posedge clk_write or negedge rst_n_write) begin
		if (!rst_n_write) begin
			wr_bin  <= '0;
			wr_gray <= '0;
			full    <= 1'b0;
		end else begin
			wr_bin  <= wr_bin_next;
			wr_gray <= wr_gray_next;
			full    <= full_next;
		end
	end

	// pointer frozen while full
	a_no_move_full: assert property (
		@(posedge clk_write) disable iff (!rst_n_write)
		full |=> $stable(wr_bin)
	) else $error("write pointer moved while full");

endmodule

// ==== verilog/cdc_fifo_read_ctrl.sv ====
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_fifo_read_ctrl
	import cdc_fifo_pkg::*;
(
	input  logic      clk_read,
	input  logic      rst_n_read,
	input  logic      read_en,
	input  ptr_t      wr_gray_sync,
	output logic      empty,
	output array_rd_t rd,
	output ptr_t      rd_gray
);

	// binary read pointer, wrap bit on top
	ptr_t rd_bin;

	// next state
	ptr_t rd_bin_next;
	ptr_t rd_gray_next;
	logic empty_next;
	logic read_accept;

	////////////////////////////////////////////////////////////////////////////
	// next pointer and empty flag
	////////////////////////////////////////////////////////////////////////////

	// reads while empty are dropped
	assign read_accept = read_en && !empty;

	always_comb begin
		// advance by one on an accepted read
		rd_bin_next  = rd_bin + ptr_t'(read_accept);
		// binary to gray
		rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

		// empty when caught up with the write pointer
		// including the wrap bit
		empty_next = (rd_gray_next == wr_gray_sync);
	end

	// array read request
	// address taken before the pointer moves
	always_comb begin
		rd.enable = read_accept;
		rd.addr   = rd_bin[`CDC_FIFO_ADDR_W-1:0];
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// empty starts high
	// rises with the read of the last word
	// falls a few edges after a write, once the gray pointer arrives
	always_ff @(posedge clk_read or negedge rst_n_read) begin
		if (!rst_n_read) begin
			rd_bin  <= '0;
			rd_gray <= '0;
			empty   <= 1'b1;
		end else begin
			rd_bin  <= rd_bin_next;
			rd_gray <= rd_gray_next;
			empty   <= empty_next;
		end
	end

	// pointer frozen while empty
	a_no_move_empty: assert property (
		@(posedge clk_read) disable iff (!rst_n_read)
		empty |=> $stable(rd_bin)
	) else $error("read pointer moved while empty");

endmodule

// ==== verilog/cdc_fifo_top.sv ====
`timescale 1ns/1ps

module cdc_fifo_top
	import cdc_fifo_pkg::*;
(
	// write domain
	input  logic  clk_write,
	input  logic  rst_n_write,
	input  data_t write_data,
	input  logic  write_en,
	output logic  full,
	// read domain
	input  logic  clk_read,
	input  logic  rst_n_read,
	input  logic  read_en,
	output data_t read_data,
	output logic  empty
);

	// array requests
	array_wr_t wr_req;
	array_rd_t rd_req;

	// gray pointers, source side
	ptr_t wr_gray;
	ptr_t rd_gray;

	// gray pointers after crossing
	ptr_t wr_gray_sync;
	ptr_t rd_gray_sync;

	////////////////////////////////////////////////////////////////////////////
	// write domain
	////////////////////////////////////////////////////////////////////////////

	cdc_fifo_write_ctrl u_write_ctrl (
		.clk_write    (clk_write),
		.rst_n_write  (rst_n_write),
		.write_data   (write_data),
		.write_en     (write_en),
		.rd_gray_sync (rd_gray_sync),
		.full         (full),
		.wr           (wr_req),
		.wr_gray      (wr_gray)
	);

	// read pointer into write clock
	gray_ptr_sync u_sync_rd2wr (
		.clk       (clk_write),
		.rst_n     (rst_n_write),
		.async_ptr (rd_gray),
		.sync_ptr  (rd_gray_sync)
	);

	////////////////////////////////////////////////////////////////////////////
	// read domain
	////////////////////////////////////////////////////////////////////////////

	cdc_fifo_read_ctrl u_read_ctrl (
		.clk_read     (clk_read),
		.rst_n_read   (rst_n_read),
		.read_en      (read_en),
		.wr_gray_sync (wr_gray_sync),
		.empty        (empty),
		.rd           (rd_req),
		.rd_gray      (rd_gray)
	);

	// write pointer into read clock
	gray_ptr_sync u_sync_wr2rd (
		.clk       (clk_read),
		.rst_n     (rst_n_read),
		.async_ptr (wr_gray),
		.sync_ptr  (wr_gray_sync)
	);

	// storage, spans both domains
	cdc_fifo_reg_array u_reg_array (
		.clk_write   (clk_write),
		.rst_n_write (rst_n_write),
		.wr          (wr_req),
		.clk_read    (clk_read),
		.rst_n_read  (rst_n_read),
		.rd          (rd_req),
		.read_data   (read_data)
	);

endmodule

// ==== verif/cdc_fifo_tb.sv ====
`timescale 1ns/1ps
`include "cdc_fifo_defs.svh"

module cdc_fifo_tb
	import cdc_fifo_pkg::*;
();

	// test sizes
	localparam int RAND_OPS     = 400;
	localparam int EXTRA_WRITES = 4;
	localparam int IDLE_READS   = 5;
	localparam int DRAIN_LIMIT  = 4 * `CDC_FIFO_DEPTH + 16;
	// every write or read strobe of all tests plus some slack
	localparam int OP_COUNT     = RAND_OPS + 4 * `CDC_FIFO_DEPTH + EXTRA_WRITES + IDLE_READS + 16;
	// write clock period in ns
	localparam int WRITE_PERIOD = 13;

	// dut signals
	logic  clk_read = 1'b0;
	logic  clk_write = 1'b0;
	logic  rst_n_read;
	logic  rst_n_write;
	data_t write_data;
	logic  write_en;
	logic  read_en;
	logic  full;
	logic  empty;
	data_t read_data;

	// reference model and bookkeeping
	data_t       model_q[$];
	data_t       expected_rd;
	logic [31:0] rng_state;
	int          err_count;
	int          check_count;
	int          test_count;
	int          failed_tests;

	// two unrelated clocks of 8 ns and 13 ns
	always #4 clk_read = ~clk_read;
	always #6.5 clk_write = ~clk_write;

	cdc_fifo_top UUT (
		.clk_write   (clk_write),
		.rst_n_write (rst_n_write),
		.write_data  (write_data),
		.write_en    (write_en),
		.full        (full),
		.clk_read    (clk_read),
		.rst_n_read  (rst_n_read),
		.read_en     (read_en),
		.read_data   (read_data),
		.empty       (empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// xorshift32 step
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("ERR at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
		end
	endtask

	// failures that are not a wrong value
	task automatic report_failure(input string msg);
		err_count++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	// one write strobe at the falling edge
	// full is stable until the next rising edge, so acceptance is known here
	task automatic write_cycle(input logic en, input data_t d, output int accepted);
		@(negedge clk_write);
		accepted   = (en && !full) ? 1 : 0;
		write_en   = en;
		write_data = d;
		if (accepted == 1) begin
			model_q.push_back(d);
		end
	endtask

	// one read strobe at the falling edge
	// read_data was loaded or held at the edge just passed
	task automatic read_cycle(input logic en, output int accepted);
		@(negedge clk_read);
		check_equal(32'(read_data), 32'(expected_rd), "read data");
		accepted = (en && !empty) ? 1 : 0;
		read_en  = en;
		if (accepted == 1) begin
			if (model_q.size() == 0) begin
				report_failure("DUT accepted a read while the model queue was empty");
			end else begin
				expected_rd = model_q.pop_front();
			end
		end
	endtask

	// read until model and dut are both empty
	// empty may stay high a few edges while a write pointer crosses
	task automatic drain_fifo(output int n);
		int acc;
		int guard;
		n     = 0;
		guard = 0;
		while ((model_q.size() > 0 || !empty) && guard < DRAIN_LIMIT) begin
			read_cycle(1'b1, acc);
			n += acc;
			guard++;
		end
		// idle cycle checks the last word
		read_cycle(1'b0, acc);
		if (guard >= DRAIN_LIMIT) begin
			report_failure("drain did not finish, FIFO never became empty");
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: FAIL, %0d errors", test_count, name,
				err_count - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int          acc;
		int          total;
		int          errs_before;
		logic [31:0] r;
		logic [31:0] wr_rands [RAND_OPS / 2];
		logic [31:0] rd_rands [RAND_OPS / 2];

		rng_state    = 32'hcecc;
		write_en     = 1'b0;
		write_data   = '0;
		read_en      = 1'b0;
		rst_n_read   = 1'b0;
		rst_n_write  = 1'b0;
		expected_rd  = '0;
		err_count    = 0;
		check_count  = 0;
		test_count   = 0;
		failed_tests = 0;

		// each reset held 5 cycles of its own clock
		fork
			begin
				repeat (5) @(posedge clk_read);
				@(negedge clk_read);
				rst_n_read = 1'b1;
			end
			begin
				repeat (5) @(posedge clk_write);
				@(negedge clk_write);
				rst_n_write = 1'b1;
			end
		join

		// 1. reset values
		errs_before = err_count;
		@(negedge clk_read);
		check_equal(32'(empty), 32'd1, "empty after reset");
		check_equal(32'(full), 32'd0, "full after reset");
		check_equal(32'(read_data), 32'd0, "read_data after reset");
		finish_test("reset values", errs_before);

		// 2. fill with read side idle
		errs_before = err_count;
		total = 0;
		for (int i = 0; i < 4 * `CDC_FIFO_DEPTH && !full; i++) begin
			r = next_random();
			write_cycle(1'b1, r[7:0], acc);
			total += acc;
		end
		check_equal(32'(full), 32'd1, "full after fill");
		check_equal(32'(total), 32'(`CDC_FIFO_DEPTH), "accepted writes before full");
		finish_test("fill until full", errs_before);

		// 3. writes while full get dropped
		errs_before = err_count;
		total = 0;
		for (int i = 0; i < EXTRA_WRITES; i++) begin
			r = next_random();
			write_cycle(1'b1, r[7:0], acc);
			total += acc;
		end
		write_cycle(1'b0, '0, acc);
		check_equal(32'(total), 32'd0, "writes accepted while full");
		drain_fifo(total);
		check_equal(32'(total), 32'(`CDC_FIFO_DEPTH), "words drained after refused writes");
		check_equal(32'(empty), 32'd1, "empty after drain");
		finish_test("refused writes", errs_before);

		// 4. reads while empty keep the last word on read_data
		errs_before = err_count;
		total = 0;
		for (int i = 0; i < IDLE_READS; i++) begin
			read_cycle(1'b1, acc);
			total += acc;
		end
		read_cycle(1'b0, acc);
		check_equal(32'(total), 32'd0, "reads accepted while empty");
		finish_test("refused reads", errs_before);

		// 5. random traffic on both sides
		// write heavy first and read heavy later so both flags get hit
		errs_before = err_count;
		// random values drawn up front, one stream per side
		for (int i = 0; i < RAND_OPS / 2; i++) begin
			wr_rands[i] = next_random();
			rd_rands[i] = next_random();
		end
		fork
			begin : write_side
				int          wacc;
				logic [31:0] wr_rand;
				for (int i = 0; i < RAND_OPS / 2; i++) begin
					wr_rand = wr_rands[i];
					write_cycle((i < RAND_OPS / 4) ? (wr_rand[1:0] != 2'b00) : wr_rand[0],
						wr_rand[15:8], wacc);
				end
				write_cycle(1'b0, '0, wacc);
			end
			begin : read_side
				int          racc;
				logic [31:0] rd_rand;
				for (int i = 0; i < RAND_OPS / 2; i++) begin
					rd_rand = rd_rands[i];
					read_cycle((i < RAND_OPS / 4) ? rd_rand[0] : (rd_rand[1:0] != 2'b00),
						racc);
				end
				read_cycle(1'b0, racc);
			end
		join
		drain_fifo(total);
		check_equal(32'(model_q.size()), 32'd0, "model queue after final drain");
		check_equal(32'(empty), 32'd1, "empty after final drain");
		finish_test("random traffic", errs_before);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, failed_tests, check_count, err_count);
		if (err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////////////////////

	// 20 write clock periods per operation
	initial begin
		#(OP_COUNT * 20 * WRITE_PERIOD);
		$display("run timed out after %0d write clock periods", OP_COUNT * 20);
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/cdc_fifo_pkg.sv
verilog/cdc_fifo_reg_array.sv
verilog/gray_ptr_sync.sv
verilog/cdc_fifo_write_ctrl.sv
verilog/cdc_fifo_read_ctrl.sv
verilog/cdc_fifo_top.sv
verif/cdc_fifo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cdc fifo testbench with verilator

TOP=cdc_fifo_tb
BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	echo "result: FAIL"
	exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
	echo "result: no completion message in $LOG"
	exit 1
fi
echo "result: PASS"
exit 0
